//--- verilog/riscv_v_pkg.sv
// Shared widths, byte-vector types and encodings for the vector bitwise unit
// Element sizes are powers of two in bytes and never wider than one beat
// osize_vector bit 3 has no fold partner within a 64-bit beat
package riscv_v_pkg;

    // Bytes per 64-bit beat
    parameter int RISCV_V_NUM_BYTES_DATA = 8;

    // Bits per byte lane
    parameter int BYTE_WIDTH = 8;

    // Default width of the beat-count field
    parameter int MAX_BEATS_W = 4;

    // One beat as byte lanes, index 0 is the least significant byte
    typedef logic [BYTE_WIDTH-1:0] riscv_v_src_byte_vector_t [RISCV_V_NUM_BYTES_DATA];

    // One valid bit per byte lane
    typedef logic [RISCV_V_NUM_BYTES_DATA-1:0] riscv_v_byte_valid_t;

    // Bitwise operator
    typedef enum logic [1:0] {
        BW_AND = 2'b00,
        BW_OR  = 2'b01,
        BW_XOR = 2'b10
    } bw_op_t;

    // Element size (SEW), value k means 2^k bytes
    typedef enum logic [1:0] {
        OSIZE_8  = 2'b00,
        OSIZE_16 = 2'b01,
        OSIZE_32 = 2'b10,
        OSIZE_64 = 2'b11
    } osize_t;

    // Bit k set when the reduction chain folds blocks 2^k bytes apart
    typedef logic [3:0] osize_vector_t;

    // Bit j set when the element is wider than 2^(j-1) bytes
    typedef logic [4:1] is_greater_osize_vector_t;

    // One-hot fold distance for a given element size
    function automatic osize_vector_t osize_to_vector(input osize_t osize);
        osize_vector_t vec;
        vec = '0;
        vec[osize] = 1'b1;
        return vec;
    endfunction

    // Element wider than 2^(j-1) bytes is the same as osize >= j
    function automatic is_greater_osize_vector_t osize_to_greater(input osize_t osize);
        is_greater_osize_vector_t vec;
        for (int j = 1; j <= 4; j++) begin
            vec[j] = (int'(osize) >= j);
        end
        return vec;
    endfunction

endpackage : riscv_v_pkg

//--- verilog/riscv_v_bw_logic.sv
// Combinational byte-lane AND/OR/XOR for one 64-bit beat
// In reduction only the low SEW element of result is meaningful
// srca carries the running partial in reduction, only its low element is read
module riscv_v_bw_logic (
    input  riscv_v_pkg::bw_op_t                    op,
    input  logic                                   is_reduct,
    input  riscv_v_pkg::osize_vector_t             osize_vector,
    input  riscv_v_pkg::is_greater_osize_vector_t  is_greater_osize_vector,
    // Source operands
    input  riscv_v_pkg::riscv_v_src_byte_vector_t  srca,
    input  riscv_v_pkg::riscv_v_src_byte_vector_t  srcb,
    input  riscv_v_pkg::riscv_v_byte_valid_t       srcb_valid,
    // Per-lane result
    output riscv_v_pkg::riscv_v_src_byte_vector_t  result
);
    import riscv_v_pkg::*;

    localparam int NUM_BW_BLOCKS = RISCV_V_NUM_BYTES_DATA;
    // Fold distances 1, 2, 4 for an 8-byte beat
    localparam int NUM_LEVELS    = $clog2(NUM_BW_BLOCKS);

    // Identity byte of the current operator
    logic [BYTE_WIDTH-1:0]    identity;
    // Block sits in the top element of the chain
    logic [NUM_BW_BLOCKS-1:0] in_top;
    // Partial byte that enters a top-element block
    riscv_v_src_byte_vector_t part_byte;
    // Result chained down from the block one element above
    riscv_v_src_byte_vector_t chain_byte;
    // Operands and result of each byte block
    riscv_v_src_byte_vector_t srca_bw;
    riscv_v_src_byte_vector_t srcb_bw;
    riscv_v_src_byte_vector_t result_bw;

    // All ones leaves AND unchanged, zero leaves OR and XOR unchanged
    assign identity = (op == BW_AND) ? '1 : '0;

    generate
        // Masked srcb bytes turn into the identity so they never disturb the fold
        for (genvar blk = 0; blk < NUM_BW_BLOCKS; blk++) begin : gen_srcb_bw
            assign srcb_bw[blk] = srcb_valid[blk] ? srcb[blk] : identity;
        end

        // Top element: the highest block always, lower ones when SEW spans them
        for (genvar blk = 0; blk < NUM_BW_BLOCKS; blk++) begin : gen_in_top
            if (blk == NUM_BW_BLOCKS-1) begin : gen_msb
                assign in_top[blk] = 1'b1;
            end else begin : gen_lower
                assign in_top[blk] = is_greater_osize_vector[$clog2(NUM_BW_BLOCKS-blk)];
            end
        end

        for (genvar blk = 0; blk < NUM_BW_BLOCKS; blk++) begin : gen_srca_bw
            // Byte of the partial's low element in the same position within its element
            always_comb begin
                part_byte[blk] = '0;
                for (int k = 0; k <= NUM_LEVELS; k++) begin
                    if (osize_vector[k]) begin
                        part_byte[blk] |= srca[blk % (2**k)];
                    end
                end
            end

            // Only distances that stay inside the beat are considered
            always_comb begin
                chain_byte[blk] = '0;
                for (int k = 0; k < $clog2(NUM_BW_BLOCKS-blk); k++) begin
                    if (osize_vector[k]) begin
                        chain_byte[blk] |= result_bw[blk + (2**k)];
                    end
                end
            end

            // Element-wise takes srca straight, reduction chains toward lane 0
            always_comb begin
                if (!is_reduct) begin
                    srca_bw[blk] = srca[blk];
                end else if (in_top[blk]) begin
                    srca_bw[blk] = part_byte[blk];
                end else begin
                    srca_bw[blk] = chain_byte[blk];
                end
            end
        end

        // Byte operator blocks
        for (genvar blk = 0; blk < NUM_BW_BLOCKS; blk++) begin : gen_bw_op
            always_comb begin
                case (op)
                    BW_AND:  result_bw[blk] = srca_bw[blk] & srcb_bw[blk];
                    BW_OR:   result_bw[blk] = srca_bw[blk] | srcb_bw[blk];
                    BW_XOR:  result_bw[blk] = srca_bw[blk] ^ srcb_bw[blk];
                    default: result_bw[blk] = '0;
                endcase
            end
            assign result[blk] = result_bw[blk];
        end
    endgenerate

endmodule : riscv_v_bw_logic

//--- verilog/riscv_v_bw_ctrl.sv
// Sequences one vector bitwise instruction from start to done
// start is honoured only while busy is low, FINISH counts as not busy
// Beat strobes outside RUN are dropped, there is no back-pressure
module riscv_v_bw_ctrl #(
    parameter int BEAT_CNT_W = riscv_v_pkg::MAX_BEATS_W
) (
    input  logic                clk,
    input  logic                arst_n,
    input  logic                start,
    input  riscv_v_pkg::bw_op_t op,
    input  riscv_v_pkg::osize_t osize,
    input  logic                is_reduct,
    input  logic                beat_valid,
    input  logic                last_beat,
    output logic                busy,
    output riscv_v_pkg::bw_op_t op_q,
    output riscv_v_pkg::osize_t osize_q,
    output logic                is_reduct_q,
    output logic                cnt_load,
    output logic                cnt_dec,
    output logic                seed_load,
    output logic                acc_en,
    output logic                out_en,
    output logic                done
);
    import riscv_v_pkg::*;

    typedef enum logic [1:0] {IDLE, RUN, FINISH} state_t;

    // Largest beat count the field can carry
    localparam int MAX_BEATS = 2**BEAT_CNT_W - 1;

    state_t                state;
    state_t                state_nxt;
    logic                  accept;
    logic                  beat_acc;
    // Beats taken so far in this instruction
    logic [BEAT_CNT_W-1:0] beats_seen;

    assign busy     = (state == RUN);
    assign done     = (state == FINISH);
    assign accept   = start && !busy;
    assign beat_acc = busy && beat_valid;

    // Counter and seed load together with the start pulse
    assign cnt_load  = accept;
    assign seed_load = accept;
    assign cnt_dec   = beat_acc;
    assign acc_en    = beat_acc;
    // Reduction publishes only the final fold
    assign out_en    = beat_acc && (!is_reduct_q || last_beat);

    always_comb begin
        state_nxt = state;
        case (state)
            IDLE:    if (start) state_nxt = RUN;
            RUN:     if (beat_valid && last_beat) state_nxt = FINISH;
            // Back-to-back start is taken while done is up
            FINISH:  state_nxt = start ? RUN : IDLE;
            default: state_nxt = IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state       <= IDLE;
            op_q        <= BW_AND;
            osize_q     <= OSIZE_8;
            is_reduct_q <= 1'b0;
            beats_seen  <= '0;
        end else begin
            state <= state_nxt;
            if (accept) begin
                op_q        <= op;
                osize_q     <= osize;
                is_reduct_q <= is_reduct;
                beats_seen  <= '0;
            end else if (beat_acc) begin
                beats_seen  <= beats_seen + 1'b1;
            end
        end
    end

    // No new instruction on top of a running one
    a_start_not_busy: assert property (@(posedge clk) disable iff (!arst_n)
        start |-> !busy) else $error("start received while busy");

    // Stray strobes are harmless but usually mean a stimulus slip
    a_beat_in_busy: assert property (@(posedge clk) disable iff (!arst_n)
        beat_valid |-> busy) else $warning("beat strobe outside an instruction dropped");

    // Counter must flag the last beat before the tally runs past the field range
    a_last_in_range: assert property (@(posedge clk) disable iff (!arst_n)
        (beat_acc && !last_beat) |-> (beats_seen < MAX_BEATS - 1))
        else $error("beat counter missed the last beat");

endmodule : riscv_v_bw_ctrl

//--- verilog/riscv_v_beat_counter.sv
// Down-counter of beats left in the current instruction
// load_value of zero is not a legal instruction length
module riscv_v_beat_counter #(
    parameter int BEAT_CNT_W = riscv_v_pkg::MAX_BEATS_W
) (
    input  logic                  clk,
    input  logic                  arst_n,
    input  logic                  load,
    input  logic [BEAT_CNT_W-1:0] load_value,
    input  logic                  dec,
    output logic                  last_beat
);

    // Beats remaining
    logic [BEAT_CNT_W-1:0] cnt;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            cnt <= '0;
        end else if (load) begin
            // Load wins, the controller never loads and decrements together
            cnt <= load_value;
        end else if (dec) begin
            cnt <= cnt - 1'b1;
        end
    end

    // One beat to go
    assign last_beat = (cnt == BEAT_CNT_W'(1));

    // Decrement at zero would wrap to the full range
    a_no_underflow: assert property (@(posedge clk) disable iff (!arst_n)
        dec |-> (cnt != '0)) else $error("beat counter decremented at zero");

endmodule : riscv_v_beat_counter

//--- verilog/riscv_v_bw_acc.sv
// Result register and reduction partial, one cycle from enable to output
// partial and reduction results keep only the low SEW element, upper bytes read as zero
// osize must be the latched size of the running instruction
module riscv_v_bw_acc (
    input  logic                                  clk,
    input  logic                                  arst_n,
    input  logic                                  seed_load,
    input  riscv_v_pkg::riscv_v_src_byte_vector_t seed,
    input  logic                                  acc_en,
    input  logic                                  out_en,
    input  logic                                  is_reduct,
    input  riscv_v_pkg::osize_t                   osize,
    input  riscv_v_pkg::riscv_v_src_byte_vector_t logic_result,
    output riscv_v_pkg::riscv_v_src_byte_vector_t partial,
    output riscv_v_pkg::riscv_v_src_byte_vector_t result,
    output logic                                  result_valid
);
    import riscv_v_pkg::*;

    riscv_v_src_byte_vector_t partial_q;
    riscv_v_src_byte_vector_t result_q;
    // Byte lane lies inside the low element
    riscv_v_byte_valid_t      elem_mask;

    always_comb begin
        for (int i = 0; i < RISCV_V_NUM_BYTES_DATA; i++) begin
            elem_mask[i] = (i < (1 << osize));
        end
    end

    // Seed and partial are stored whole; the mask below trims them to SEW
    always_ff @(posedge clk) begin
        if (seed_load) begin
            partial_q <= seed;
        end else if (acc_en && is_reduct) begin
            partial_q <= logic_result;
        end
    end

    // Upper bytes of a reduction are cleared, element-wise passes all lanes
    always_ff @(posedge clk) begin
        if (out_en) begin
            for (int i = 0; i < RISCV_V_NUM_BYTES_DATA; i++) begin
                result_q[i] <= (is_reduct && !elem_mask[i]) ? '0 : logic_result[i];
            end
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            result_valid <= 1'b0;
        end else begin
            result_valid <= out_en;
        end
    end

    // Low element only goes back to the logic block
    always_comb begin
        for (int i = 0; i < RISCV_V_NUM_BYTES_DATA; i++) begin
            partial[i] = elem_mask[i] ? partial_q[i] : '0;
        end
    end

    assign result = result_q;

endmodule : riscv_v_bw_acc

//--- verilog/riscv_v_bw_unit.sv
// Vector bitwise unit: element-wise AND/OR/XOR or reduction to one SEW element
// Beats are plain strobes taken only while busy; no back-pressure
// num_beats must be nonzero
module riscv_v_bw_unit #(
    parameter int BEAT_CNT_W = riscv_v_pkg::MAX_BEATS_W
) (
    input  logic                                  clk,
    input  logic                                  arst_n,
    // Instruction start
    input  logic                                  start,
    input  riscv_v_pkg::bw_op_t                   op,
    input  riscv_v_pkg::osize_t                   osize,
    input  logic                                  is_reduct,
    input  logic [BEAT_CNT_W-1:0]                 num_beats,
    input  riscv_v_pkg::riscv_v_src_byte_vector_t seed,
    // Beat strobe
    input  logic                                  beat_valid,
    input  riscv_v_pkg::riscv_v_src_byte_vector_t srca,
    input  riscv_v_pkg::riscv_v_src_byte_vector_t srcb,
    input  riscv_v_pkg::riscv_v_byte_valid_t      srcb_valid,
    // Results and status
    output riscv_v_pkg::riscv_v_src_byte_vector_t result,
    output logic                                  result_valid,
    output logic                                  done,
    output logic                                  busy
);
    import riscv_v_pkg::*;

    bw_op_t                   op_q;
    osize_t                   osize_q;
    logic                     is_reduct_q;
    logic                     cnt_load;
    logic                     cnt_dec;
    logic                     seed_load;
    logic                     acc_en;
    logic                     out_en;
    logic                     last_beat;
    osize_vector_t            osize_vector;
    is_greater_osize_vector_t is_greater_osize_vector;
    riscv_v_src_byte_vector_t logic_srca;
    riscv_v_src_byte_vector_t logic_result;
    riscv_v_src_byte_vector_t partial;

    // Chain controls follow the latched element size
    assign osize_vector            = osize_to_vector(osize_q);
    assign is_greater_osize_vector = osize_to_greater(osize_q);

    // Reduction feeds the running partial back in place of srca
    generate
        for (genvar i = 0; i < RISCV_V_NUM_BYTES_DATA; i++) begin : gen_srca_mux
            assign logic_srca[i] = is_reduct_q ? partial[i] : srca[i];
        end
    endgenerate

    riscv_v_bw_ctrl #(
        .BEAT_CNT_W(BEAT_CNT_W)
    ) u_ctrl (
        .clk         (clk),
        .arst_n      (arst_n),
        .start       (start),
        .op          (op),
        .osize       (osize),
        .is_reduct   (is_reduct),
        .beat_valid  (beat_valid),
        .last_beat   (last_beat),
        .busy        (busy),
        .op_q        (op_q),
        .osize_q     (osize_q),
        .is_reduct_q (is_reduct_q),
        .cnt_load    (cnt_load),
        .cnt_dec     (cnt_dec),
        .seed_load   (seed_load),
        .acc_en      (acc_en),
        .out_en      (out_en),
        .done        (done)
    );

    riscv_v_beat_counter #(
        .BEAT_CNT_W(BEAT_CNT_W)
    ) u_beat_counter (
        .clk        (clk),
        .arst_n     (arst_n),
        .load       (cnt_load),
        .load_value (num_beats),
        .dec        (cnt_dec),
        .last_beat  (last_beat)
    );

    riscv_v_bw_logic u_bw_logic (
        .op                      (op_q),
        .is_reduct               (is_reduct_q),
        .osize_vector            (osize_vector),
        .is_greater_osize_vector (is_greater_osize_vector),
        .srca                    (logic_srca),
        .srcb                    (srcb),
        .srcb_valid              (srcb_valid),
        .result                  (logic_result)
    );

    riscv_v_bw_acc u_bw_acc (
        .clk          (clk),
        .arst_n       (arst_n),
        .seed_load    (seed_load),
        .seed         (seed),
        .acc_en       (acc_en),
        .out_en       (out_en),
        .is_reduct    (is_reduct_q),
        .osize        (osize_q),
        .logic_result (logic_result),
        .partial      (partial),
        .result       (result),
        .result_valid (result_valid)
    );

endmodule : riscv_v_bw_unit

//--- testbench/riscv_v_bw_unit_tb.sv
// Table-driven testbench for the vector bitwise unit
// Cases run back to back, each start lands in the done cycle of the case before
// srcb_valid is one pattern per case and holds for all of its beats
module riscv_v_bw_unit_tb;
    timeunit 1ns;
    timeprecision 1ps;
    import riscv_v_pkg::*;

    localparam int NUM_CASES = 11;
    localparam int BEAT_CNT_W = MAX_BEATS_W;

    logic clk;
    logic arst_n;
    logic start;
    bw_op_t op;
    osize_t osize;
    logic is_reduct;
    logic [BEAT_CNT_W-1:0] num_beats;
    riscv_v_src_byte_vector_t seed;
    logic beat_valid;
    riscv_v_src_byte_vector_t srca;
    riscv_v_src_byte_vector_t srcb;
    riscv_v_byte_valid_t srcb_valid;
    riscv_v_src_byte_vector_t result;
    logic result_valid;
    logic done;
    logic busy;

    // Stimulus table
    string case_name [NUM_CASES];
    bw_op_t case_op [NUM_CASES];
    osize_t case_osize [NUM_CASES];
    logic case_red [NUM_CASES];
    int case_beats [NUM_CASES];
    logic [7:0] case_valid [NUM_CASES];

    // Expected results, oldest first
    logic [63:0] exp_data_q [$];
    int exp_case_q [$];
    // Beat driven now should produce a result, and the final one
    logic out_due;
    logic out_last;
    logic due_q;
    logic last_q;
    // Case that the beat driven now belongs to
    int out_case;
    int due_case;
    // Instruction in flight, busy must follow it
    logic run_exp;
    int cur_case;
    int done_count;
    int data_errors;
    int timing_errors;
    int cycles;
    int timeout_limit;
    integer rng_seed;

    riscv_v_bw_unit #(
        .BEAT_CNT_W(BEAT_CNT_W)
    ) DUT (
        .clk          (clk),
        .arst_n       (arst_n),
        .start        (start),
        .op           (op),
        .osize        (osize),
        .is_reduct    (is_reduct),
        .num_beats    (num_beats),
        .seed         (seed),
        .beat_valid   (beat_valid),
        .srca         (srca),
        .srcb         (srcb),
        .srcb_valid   (srcb_valid),
        .result       (result),
        .result_valid (result_valid),
        .done         (done),
        .busy         (busy)
    );

    always #50 clk = ~clk;

    task automatic add_case(input int idx, input string name, input bw_op_t o,
                            input osize_t os, input logic red, input int beats,
                            input logic [7:0] valid);
        case_name[idx]  = name;
        case_op[idx]    = o;
        case_osize[idx] = os;
        case_red[idx]   = red;
        case_beats[idx] = beats;
        case_valid[idx] = valid;
    endtask

    // Table name, or the stray beat before the first case
    function automatic string case_label(input int idx);
        return (idx < 0) ? "stray_beat" : case_name[idx];
    endfunction

    // All ones for AND, zero for OR and XOR
    function automatic logic [7:0] identity_byte(input bw_op_t o);
        return (o == BW_AND) ? 8'hff : 8'h00;
    endfunction

    function automatic logic [7:0] apply_op(input bw_op_t o, input logic [7:0] a,
                                            input logic [7:0] b);
        case (o)
            BW_AND:  return a & b;
            BW_OR:   return a | b;
            BW_XOR:  return a ^ b;
            default: return 8'h00;
        endcase
    endfunction

    // Ones over the low SEW element
    function automatic logic [63:0] sew_mask(input osize_t os);
        logic [63:0] m;
        m = '0;
        for (int i = 0; i < (1 << int'(os)); i++) begin
            m[i*BYTE_WIDTH +: BYTE_WIDTH] = 8'hff;
        end
        return m;
    endfunction

    function automatic logic [63:0] elementwise_model(input bw_op_t o, input logic [63:0] a,
                                                      input logic [63:0] b,
                                                      input logic [7:0] valid);
        logic [63:0] r;
        logic [7:0]  bb;
        for (int i = 0; i < RISCV_V_NUM_BYTES_DATA; i++) begin
            bb = valid[i] ? b[i*BYTE_WIDTH +: BYTE_WIDTH] : identity_byte(o);
            r[i*BYTE_WIDTH +: BYTE_WIDTH] = apply_op(o, a[i*BYTE_WIDTH +: BYTE_WIDTH], bb);
        end
        return r;
    endfunction

    // Fold every SEW element of one beat into the partial, bytes above SEW are zero
    function automatic logic [63:0] reduce_model(input bw_op_t o, input osize_t os,
                                                 input logic [63:0] part, input logic [63:0] b,
                                                 input logic [7:0] valid);
        logic [63:0] acc;
        logic [7:0]  bb;
        int          sew;
        sew = 1 << int'(os);
        acc = part & sew_mask(os);
        for (int e = 0; e < RISCV_V_NUM_BYTES_DATA; e += sew) begin
            for (int i = 0; i < sew; i++) begin
                bb = valid[e+i] ? b[(e+i)*BYTE_WIDTH +: BYTE_WIDTH] : identity_byte(o);
                acc[i*BYTE_WIDTH +: BYTE_WIDTH] = apply_op(o, acc[i*BYTE_WIDTH +: BYTE_WIDTH], bb);
            end
        end
        return acc;
    endfunction

    task automatic drive_beat(input logic [63:0] a, input logic [63:0] b,
                              input logic [7:0] valid, input logic due, input logic last);
        for (int i = 0; i < RISCV_V_NUM_BYTES_DATA; i++) begin
            srca[i] <= a[i*BYTE_WIDTH +: BYTE_WIDTH];
            srcb[i] <= b[i*BYTE_WIDTH +: BYTE_WIDTH];
        end
        srcb_valid <= valid;
        beat_valid <= 1'b1;
        out_due    <= due;
        out_last   <= last;
        out_case   <= cur_case;
    endtask

    // Hang guard
    always @(posedge clk) begin
        cycles++;
        if (cycles > timeout_limit) begin
            $display("Timeout: the run hung, %0d cycles passed without all cases done", cycles);
            $display("Simulation FAILED");
            $finish;
        end
    end

    // Outputs are sampled mid-cycle, away from the driving edge
    always @(negedge clk) begin
        logic [63:0] got;
        logic [63:0] want;
        int          idx;
        if (arst_n) begin
            assert (result_valid == due_q) else begin
                $display("ERROR %s: result_valid expected %0b actual %0b",
                         case_label(due_case), due_q, result_valid);
                timing_errors++;
            end
            assert (done == (due_q && last_q)) else begin
                $display("ERROR %s: done expected %0b actual %0b",
                         case_label(due_case), due_q && last_q, done);
                timing_errors++;
            end
            // High from the cycle after start, low again in the done cycle
            assert (busy == run_exp) else begin
                $display("ERROR %s: busy expected %0b actual %0b",
                         case_label(cur_case), run_exp, busy);
                timing_errors++;
            end
            if (done) begin
                done_count++;
            end
            if (result_valid && exp_data_q.size() > 0) begin
                want = exp_data_q.pop_front();
                idx  = exp_case_q.pop_front();
                for (int i = 0; i < RISCV_V_NUM_BYTES_DATA; i++) begin
                    got[i*BYTE_WIDTH +: BYTE_WIDTH] = result[i];
                end
                assert (got == want) else begin
                    $display("ERROR %s: result expected %h actual %h", case_name[idx], want, got);
                    data_errors++;
                end
            end
        end
        due_q    = out_due;
        last_q   = out_last;
        due_case = out_case;
    end

    initial begin
        logic [63:0] a64;
        logic [63:0] b64;
        logic [63:0] seed64;
        logic [63:0] part64;
        logic        last_b;
        int          total_beats;
        clk        = 1'b0;
        arst_n     = 1'b0;
        start      = 1'b0;
        op         = BW_AND;
        osize      = OSIZE_8;
        is_reduct  = 1'b0;
        num_beats  = '0;
        beat_valid = 1'b0;
        srcb_valid = '0;
        for (int i = 0; i < RISCV_V_NUM_BYTES_DATA; i++) begin
            seed[i] = '0;
            srca[i] = '0;
            srcb[i] = '0;
        end
        out_due       = 1'b0;
        out_last      = 1'b0;
        due_q         = 1'b0;
        last_q        = 1'b0;
        out_case      = -1;
        due_case      = -1;
        run_exp       = 1'b0;
        cur_case      = -1;
        done_count    = 0;
        data_errors   = 0;
        timing_errors = 0;
        cycles        = 0;
        rng_seed      = 32'h3ff4;

        add_case(0,  "ew_and",             BW_AND, OSIZE_8,  1'b0, 3, 8'hff);
        add_case(1,  "ew_or_partial",      BW_OR,  OSIZE_8,  1'b0, 3, 8'hb7);
        add_case(2,  "ew_xor_partial",     BW_XOR, OSIZE_8,  1'b0, 3, 8'h5a);
        add_case(3,  "red_and_sew8",       BW_AND, OSIZE_8,  1'b1, 2, 8'hff);
        add_case(4,  "red_or_sew16",       BW_OR,  OSIZE_16, 1'b1, 2, 8'hff);
        add_case(5,  "red_xor_sew32",      BW_XOR, OSIZE_32, 1'b1, 2, 8'hff);
        add_case(6,  "red_and_sew64",      BW_AND, OSIZE_64, 1'b1, 2, 8'hff);
        add_case(7,  "red_xor_sew8_mask",  BW_XOR, OSIZE_8,  1'b1, 3, 8'h3c);
        add_case(8,  "red_and_sew16_mask", BW_AND, OSIZE_16, 1'b1, 2, 8'hf3);
        add_case(9,  "red_or_sew64_mask",  BW_OR,  OSIZE_64, 1'b1, 2, 8'h81);
        add_case(10, "ew_and_single",      BW_AND, OSIZE_8,  1'b0, 1, 8'hff);
        total_beats = 0;
        for (int c = 0; c < NUM_CASES; c++) begin
            total_beats += case_beats[c];
        end
        timeout_limit = (total_beats + 4 * NUM_CASES) * 2;

        // Reset for two cycles, then all status outputs must be quiet
        repeat (2) @(posedge clk);
        arst_n <= 1'b1;
        @(negedge clk);
        assert (!busy && !done && !result_valid) else begin
            $display("ERROR reset: busy/done/result_valid expected 000 actual %b%b%b",
                     busy, done, result_valid);
            timing_errors++;
        end

        // Beat with no start must give no result
        @(posedge clk);
        drive_beat({$random(rng_seed), $random(rng_seed)}, {$random(rng_seed), $random(rng_seed)},
                   8'hff, 1'b0, 1'b0);
        @(posedge clk);
        beat_valid <= 1'b0;
        @(posedge clk);

        for (int c = 0; c < NUM_CASES; c++) begin
            cur_case = c;
            seed64 = {$random(rng_seed), $random(rng_seed)};
            start     <= 1'b1;
            op        <= case_op[c];
            osize     <= case_osize[c];
            is_reduct <= case_red[c];
            num_beats <= BEAT_CNT_W'(case_beats[c]);
            for (int i = 0; i < RISCV_V_NUM_BYTES_DATA; i++) begin
                seed[i] <= seed64[i*BYTE_WIDTH +: BYTE_WIDTH];
            end
            part64 = seed64 & sew_mask(case_osize[c]);
            @(posedge clk);
            start   <= 1'b0;
            run_exp <= 1'b1;
            for (int b = 0; b < case_beats[c]; b++) begin
                a64 = {$random(rng_seed), $random(rng_seed)};
                b64 = {$random(rng_seed), $random(rng_seed)};
                last_b = (b == case_beats[c] - 1);
                if (case_red[c]) begin
                    part64 = reduce_model(case_op[c], case_osize[c], part64, b64, case_valid[c]);
                    if (last_b) begin
                        exp_data_q.push_back(part64);
                        exp_case_q.push_back(c);
                    end
                    drive_beat(a64, b64, case_valid[c], last_b, last_b);
                end else begin
                    exp_data_q.push_back(elementwise_model(case_op[c], a64, b64, case_valid[c]));
                    exp_case_q.push_back(c);
                    drive_beat(a64, b64, case_valid[c], 1'b1, last_b);
                end
                @(posedge clk);
            end
            // Next start goes out on this same edge, during done
            beat_valid <= 1'b0;
            out_due    <= 1'b0;
            out_last   <= 1'b0;
            run_exp    <= 1'b0;
        end

        while (done_count < NUM_CASES) begin
            @(posedge clk);
        end
        @(negedge clk);
        assert (exp_data_q.size() == 0) else begin
            $display("Missing results: %0d expected results never arrived", exp_data_q.size());
            data_errors++;
        end
        assert (done_count == NUM_CASES) else begin
            $display("ERROR done_count: expected %0d actual %0d", NUM_CASES, done_count);
            timing_errors++;
        end

        $display("Errors: %0d data, %0d timing, %0d total", data_errors, timing_errors,
                 data_errors + timing_errors);
        if (data_errors + timing_errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule : riscv_v_bw_unit_tb

//--- verilog.f
verilog/riscv_v_pkg.sv
verilog/riscv_v_bw_logic.sv
verilog/riscv_v_bw_ctrl.sv
verilog/riscv_v_beat_counter.sv
verilog/riscv_v_bw_acc.sv
verilog/riscv_v_bw_unit.sv
testbench/riscv_v_bw_unit_tb.sv

//--- run_sim.sh
#!/bin/sh
# Compile and run the vector bitwise unit testbench with Verilator
cd "$(dirname "$0")" || exit 1
LOG=sim.log

if ! verilator --binary --timing --assert -Wno-fatal -f verilog.f \
        --top-module riscv_v_bw_unit_tb -Mdir obj_dir -o sim_tb; then
    echo "Verilator compile failed"
    exit 1
fi

./obj_dir/sim_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ "$status" -ne 0 ]; then
    echo "Simulator exited with status $status"
    exit 1
fi

if grep -q "Simulation FAILED" "$LOG"; then
    exit 1
fi
if ! grep -q "Simulation PASSED" "$LOG"; then
    echo "Simulation ended without a result line"
    exit 1
fi
exit 0
